// File: csa_pkg.sv
package csa_pkg;

	localparam int WORD_W = 32;
	localparam int OUT_W = 2 * WORD_W;
	localparam int JOB_WORDS = 5;
	localparam int RESULT_WORDS = 7;
	localparam int WORD_CNT_W = 3;
	localparam int CATCH_WORD = 5; // Low word of out.
	localparam int CALC_UNITS = 4;
	localparam int UNIT_IDX_W = 2;
	localparam int ITER_W = 4;
	localparam int CATCH_IDX_W = 8;
	localparam int CATCH_BINS = 1 << CATCH_IDX_W;
	localparam int CATCH_CNT_W = 16;
	localparam int IDLE_DEBOUNCE = 100;
	localparam int IDLE_CNT_W = $clog2(IDLE_DEBOUNCE);

	localparam int LD_STATE_W = 3;
	localparam logic [LD_STATE_W-1:0] LD_IDLE = 3'd0;
	localparam logic [LD_STATE_W-1:0] LD_READ = 3'd1;
	localparam logic [LD_STATE_W-1:0] LD_CAPT = 3'd2;
	localparam logic [LD_STATE_W-1:0] LD_DISP = 3'd3;
	localparam logic [LD_STATE_W-1:0] LD_NEXT = 3'd4;

	localparam int ST_STATE_W = 2;
	localparam logic [ST_STATE_W-1:0] ST_WAIT = 2'd0;
	localparam logic [ST_STATE_W-1:0] ST_HOLD = 2'd1;
	localparam logic [ST_STATE_W-1:0] ST_SEND = 2'd2;
	localparam logic [ST_STATE_W-1:0] ST_NEXT = 2'd3;

	typedef logic [WORD_W-1:0] csa_word_t;

	typedef struct packed {
		logic [OUT_W-1:0] out;
		logic [WORD_W-1:0] times_start;
		logic [WORD_W-1:0] times;
		logic [OUT_W-1:0] key_in;
		logic [WORD_W-1:0] block;
	} csa_fields_t;

	typedef union packed {
		csa_fields_t fields;
		csa_word_t [RESULT_WORDS-1:0] words; // Word 0 is block, word 6 is out high.
	} csa_result_u;

endpackage

// File: csa_job_loader.sv
module csa_job_loader (
	input logic csa_out_wclk,
	input logic rst_n,
	input logic in_ready_i,
	input csa_pkg::csa_word_t in_rdata_i,
	input logic [csa_pkg::CALC_UNITS-1:0] unit_full_i,
	output logic in_ren_o,
	output logic [csa_pkg::CALC_UNITS-1:0] unit_wen_o,
	output csa_pkg::csa_result_u job_o
);

	logic [csa_pkg::LD_STATE_W-1:0] state;
	logic [csa_pkg::WORD_CNT_W-1:0] req_cnt;
	logic [csa_pkg::WORD_CNT_W-1:0] cap_cnt;
	logic [1:0] ren_pipe; // Matches the two-cycle read latency of the input FIFO.
	logic [csa_pkg::UNIT_IDX_W-1:0] idx;
	csa_pkg::csa_result_u job_q;

	always_ff @(posedge csa_out_wclk) begin
		if (!rst_n) begin
			state <= csa_pkg::LD_IDLE;
			in_ren_o <= 1'b0;
			unit_wen_o <= '0;
			req_cnt <= '0;
			cap_cnt <= '0;
			ren_pipe <= '0;
			idx <= '0;
		end else begin
			unit_wen_o <= '0;
			ren_pipe <= {ren_pipe[0], in_ren_o};
			if (ren_pipe[1]) begin
				cap_cnt <= cap_cnt + 1'b1;
			end
			case (state)
				csa_pkg::LD_IDLE: begin
					if (in_ready_i) begin
						in_ren_o <= 1'b1;
						req_cnt <= '0;
						cap_cnt <= '0;
						state <= csa_pkg::LD_READ;
					end
				end
				csa_pkg::LD_READ: begin
					if (req_cnt == csa_pkg::JOB_WORDS - 1) begin
						in_ren_o <= 1'b0;
						state <= csa_pkg::LD_CAPT;
					end else begin
						req_cnt <= req_cnt + 1'b1;
					end
				end
				csa_pkg::LD_CAPT: begin
					if (ren_pipe[1] && cap_cnt == csa_pkg::JOB_WORDS - 1) begin
						state <= csa_pkg::LD_DISP;
					end
				end
				csa_pkg::LD_DISP: begin
					if (!unit_full_i[idx]) begin
						unit_wen_o[idx] <= 1'b1;
						state <= csa_pkg::LD_NEXT;
					end
				end
				csa_pkg::LD_NEXT: begin
					if (idx == csa_pkg::CALC_UNITS - 1) begin
						idx <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
					state <= csa_pkg::LD_IDLE;
				end
				default: begin
					state <= csa_pkg::LD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge csa_out_wclk) begin
		if (state == csa_pkg::LD_IDLE) begin
			job_q.words[csa_pkg::RESULT_WORDS-1:csa_pkg::JOB_WORDS] <= '0; // A job carries no out.
		end
		if (ren_pipe[1]) begin
			job_q.words[cap_cnt] <= in_rdata_i;
		end
	end

	assign job_o = job_q;

endmodule

// File: csa_calc_unit.sv
module csa_calc_unit (
	input logic csa_out_wclk,
	input logic rst_n,
	input logic wen_i,
	input csa_pkg::csa_result_u job_i,
	output logic full_o,
	output logic empty_o,
	output logic ready_o,
	input logic ren_i,
	output csa_pkg::csa_result_u result_o
);

	csa_pkg::csa_result_u rec;
	logic [csa_pkg::ITER_W-1:0] iter_left;
	logic full_q;
	logic ready_q;
	logic step;

	assign step = full_q && !ready_q; // One kernel iteration per cycle while busy.

	always_ff @(posedge csa_out_wclk) begin
		if (!rst_n) begin
			full_q <= 1'b0;
			ready_q <= 1'b0;
			iter_left <= '0;
		end else if (ren_i) begin
			full_q <= 1'b0;
			ready_q <= 1'b0;
		end else if (wen_i) begin
			full_q <= 1'b1;
			iter_left <= job_i.fields.times[csa_pkg::ITER_W-1:0];
			ready_q <= (job_i.fields.times[csa_pkg::ITER_W-1:0] == '0);
		end else if (step) begin
			iter_left <= iter_left - 1'b1;
			if (iter_left == 1) begin
				ready_q <= 1'b1;
			end
		end
	end

	// The out field doubles as the kernel accumulator.
	always_ff @(posedge csa_out_wclk) begin
		if (wen_i) begin
			rec <= job_i;
			rec.fields.out <= job_i.fields.key_in;
		end else if (step) begin
			rec.fields.out <= {rec.fields.out[csa_pkg::OUT_W-2:0], rec.fields.out[csa_pkg::OUT_W-1]}
				^ {rec.fields.times_start, rec.fields.block};
		end
	end

	assign full_o = full_q;
	assign empty_o = ~full_q;
	assign ready_o = ready_q;
	assign result_o = rec;

endmodule

// File: csa_result_streamer.sv
module csa_result_streamer (
	input logic csa_out_wclk,
	input logic rst_n,
	input logic [csa_pkg::CALC_UNITS-1:0] unit_ready_i,
	input csa_pkg::csa_result_u unit_result_i [csa_pkg::CALC_UNITS],
	output logic [csa_pkg::CALC_UNITS-1:0] unit_ren_o,
	input logic out_full_i,
	output logic out_wen_o,
	output csa_pkg::csa_word_t out_wdata_o,
	output logic catch_hit_o,
	output logic [csa_pkg::CATCH_IDX_W-1:0] catch_index_o
);

	logic [csa_pkg::ST_STATE_W-1:0] state;
	logic [csa_pkg::WORD_CNT_W-1:0] word_cnt;
	logic [csa_pkg::UNIT_IDX_W-1:0] idx;
	logic send;
	csa_pkg::csa_result_u rec_q;

	// Full is looked at only before word 0, a started burst always runs to the end.
	assign send = (state == csa_pkg::ST_HOLD && !out_full_i) || state == csa_pkg::ST_SEND;

	always_ff @(posedge csa_out_wclk) begin
		if (!rst_n) begin
			state <= csa_pkg::ST_WAIT;
			unit_ren_o <= '0;
			out_wen_o <= 1'b0;
			catch_hit_o <= 1'b0;
			word_cnt <= '0;
			idx <= '0;
		end else begin
			unit_ren_o <= '0;
			out_wen_o <= 1'b0;
			catch_hit_o <= 1'b0;
			case (state)
				csa_pkg::ST_WAIT: begin
					if (unit_ready_i[idx]) begin
						unit_ren_o[idx] <= 1'b1;
						state <= csa_pkg::ST_HOLD;
					end
				end
				csa_pkg::ST_HOLD, csa_pkg::ST_SEND: begin
					if (send) begin
						out_wen_o <= 1'b1;
						catch_hit_o <= (word_cnt == csa_pkg::CATCH_WORD);
						if (word_cnt == csa_pkg::RESULT_WORDS - 1) begin
							word_cnt <= '0;
							state <= csa_pkg::ST_NEXT;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state <= csa_pkg::ST_SEND;
						end
					end
				end
				csa_pkg::ST_NEXT: begin
					if (idx == csa_pkg::CALC_UNITS - 1) begin
						idx <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
					state <= csa_pkg::ST_WAIT;
				end
				default: begin
					state <= csa_pkg::ST_WAIT;
				end
			endcase
		end
	end

	always_ff @(posedge csa_out_wclk) begin
		if (state == csa_pkg::ST_WAIT && unit_ready_i[idx]) begin
			rec_q <= unit_result_i[idx]; // Taken in the cycle the release pulse is set.
		end
		if (send) begin
			out_wdata_o <= rec_q.words[word_cnt];
		end
		if (send && word_cnt == csa_pkg::CATCH_WORD) begin
			catch_index_o <= rec_q.words[csa_pkg::CATCH_WORD][csa_pkg::CATCH_IDX_W-1:0];
		end
	end

endmodule

// File: csa_catch_histogram.sv
module csa_catch_histogram (
	input logic csa_out_wclk,
	input logic rst_n,
	input logic hit_i,
	input logic [csa_pkg::CATCH_IDX_W-1:0] hit_index_i,
	input logic clear_i,
	input logic [csa_pkg::CATCH_IDX_W-1:0] read_index_i,
	output logic [csa_pkg::CATCH_CNT_W-1:0] count_o
);

	logic [csa_pkg::CATCH_CNT_W-1:0] cnt [csa_pkg::CATCH_BINS];

	always_ff @(posedge csa_out_wclk) begin
		if (!rst_n || clear_i) begin
			for (int i = 0; i < csa_pkg::CATCH_BINS; i++) begin
				cnt[i] <= '0; // Clear takes priority over a hit in the same cycle.
			end
		end else if (hit_i) begin
			cnt[hit_index_i] <= cnt[hit_index_i] + 1'b1;
		end
	end

	assign count_o = cnt[read_index_i];

endmodule

// File: csa_idle_monitor.sv
module csa_idle_monitor (
	input logic csa_out_wclk,
	input logic rst_n,
	input logic [csa_pkg::CALC_UNITS-1:0] unit_empty_i,
	output logic idle_o
);

	logic [csa_pkg::IDLE_CNT_W-1:0] cnt;
	logic all_empty;

	assign all_empty = &unit_empty_i;

	always_ff @(posedge csa_out_wclk) begin
		if (!rst_n) begin
			cnt <= '0;
			idle_o <= 1'b0;
		end else begin
			// Rises after IDLE_DEBOUNCE empty cycles in a row and drops right after a busy one.
			idle_o <= all_empty && (cnt == csa_pkg::IDLE_DEBOUNCE - 1);
			if (!all_empty) begin
				cnt <= '0;
			end else if (cnt != csa_pkg::IDLE_DEBOUNCE - 1) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// File: csa_farm_top.sv
module csa_farm_top (
	input logic csa_out_wclk,
	input logic rst_n,
	input logic in_ready_i,
	output logic in_ren_o,
	input csa_pkg::csa_word_t in_rdata_i,
	input logic out_full_i,
	output logic out_wen_o,
	output csa_pkg::csa_word_t out_wdata_o,
	input logic catch_clear_i,
	input logic [csa_pkg::CATCH_IDX_W-1:0] catch_index_i,
	output logic [csa_pkg::CATCH_CNT_W-1:0] catch_count_o,
	output logic idle_o
);

	logic [csa_pkg::CALC_UNITS-1:0] unit_full;
	logic [csa_pkg::CALC_UNITS-1:0] unit_empty;
	logic [csa_pkg::CALC_UNITS-1:0] unit_ready;
	logic [csa_pkg::CALC_UNITS-1:0] unit_wen;
	logic [csa_pkg::CALC_UNITS-1:0] unit_ren;
	csa_pkg::csa_result_u job;
	csa_pkg::csa_result_u unit_result [csa_pkg::CALC_UNITS];
	logic catch_hit;
	logic [csa_pkg::CATCH_IDX_W-1:0] catch_index;

	csa_job_loader u_loader (
		.csa_out_wclk(csa_out_wclk),
		.rst_n(rst_n),
		.in_ready_i(in_ready_i),
		.in_rdata_i(in_rdata_i),
		.unit_full_i(unit_full),
		.in_ren_o(in_ren_o),
		.unit_wen_o(unit_wen),
		.job_o(job)
	);

	for (genvar i = 0; i < csa_pkg::CALC_UNITS; i++) begin : gen_unit
		csa_calc_unit u_unit (
			.csa_out_wclk(csa_out_wclk),
			.rst_n(rst_n),
			.wen_i(unit_wen[i]),
			.job_i(job), // All units share the job bus, the write pulse selects one.
			.full_o(unit_full[i]),
			.empty_o(unit_empty[i]),
			.ready_o(unit_ready[i]),
			.ren_i(unit_ren[i]),
			.result_o(unit_result[i])
		);
	end

	csa_result_streamer u_streamer (
		.csa_out_wclk(csa_out_wclk),
		.rst_n(rst_n),
		.unit_ready_i(unit_ready),
		.unit_result_i(unit_result),
		.unit_ren_o(unit_ren),
		.out_full_i(out_full_i),
		.out_wen_o(out_wen_o),
		.out_wdata_o(out_wdata_o),
		.catch_hit_o(catch_hit),
		.catch_index_o(catch_index)
	);

	csa_catch_histogram u_histogram (
		.csa_out_wclk(csa_out_wclk),
		.rst_n(rst_n),
		.hit_i(catch_hit),
		.hit_index_i(catch_index),
		.clear_i(catch_clear_i),
		.read_index_i(catch_index_i),
		.count_o(catch_count_o)
	);

	csa_idle_monitor u_idle (
		.csa_out_wclk(csa_out_wclk),
		.rst_n(rst_n),
		.unit_empty_i(unit_empty),
		.idle_o(idle_o)
	);

endmodule

// File: csa_farm_chk.sv
module csa_farm_chk (
	input logic csa_out_wclk,
	input logic rst_n,
	input logic in_ren_o,
	input logic out_wen_o
);

	int fail_cnt = 0;

	reset_quiet: assert property (@(posedge csa_out_wclk)
		!rst_n |=> (!in_ren_o && !out_wen_o))
		else begin
			$error("read or write enable active in reset");
			fail_cnt++;
		end

	// An output burst is one whole result record.
	burst_seven: assert property (@(posedge csa_out_wclk) disable iff (!rst_n)
		$rose(out_wen_o) |-> out_wen_o [*7] ##1 !out_wen_o)
		else begin
			$error("output burst is not seven words long");
			fail_cnt++;
		end

	job_read_five: assert property (@(posedge csa_out_wclk) disable iff (!rst_n)
		$rose(in_ren_o) |-> in_ren_o [*5] ##1 !in_ren_o)
		else begin
			$error("job read is not five words long");
			fail_cnt++;
		end

endmodule

bind csa_farm_top csa_farm_chk u_chk (
	.csa_out_wclk(csa_out_wclk),
	.rst_n(rst_n),
	.in_ren_o(in_ren_o),
	.out_wen_o(out_wen_o)
);

// File: tb_csa_farm.sv
module tb_csa_farm;

	logic csa_out_wclk;
	logic rst_n;
	logic in_ready_i;
	logic in_ren_o;
	csa_pkg::csa_word_t in_rdata_i;
	logic out_full_i;
	logic out_wen_o;
	csa_pkg::csa_word_t out_wdata_o;
	logic catch_clear_i;
	logic [csa_pkg::CATCH_IDX_W-1:0] catch_index_i;
	logic [csa_pkg::CATCH_CNT_W-1:0] catch_count_o;
	logic idle_o;

	csa_pkg::csa_word_t job_words [$];
	csa_pkg::csa_word_t exp_lo [$];
	csa_pkg::csa_word_t exp_hi [$];
	logic [127:0] case_names [$];
	csa_pkg::csa_word_t got_words [$];
	logic [csa_pkg::CATCH_CNT_W-1:0] exp_cnt [csa_pkg::CATCH_BINS];
	csa_pkg::csa_word_t rd_stage;
	logic full_seen = 1'b0;
	int rd_ptr = 0;
	int burst_len = 0;
	int cycles = 0;
	int cycle_limit = 400;
	integer seed = 15090;

	csa_farm_top dut0 (
		.csa_out_wclk(csa_out_wclk),
		.rst_n(rst_n),
		.in_ready_i(in_ready_i),
		.in_ren_o(in_ren_o),
		.in_rdata_i(in_rdata_i),
		.out_full_i(out_full_i),
		.out_wen_o(out_wen_o),
		.out_wdata_o(out_wdata_o),
		.catch_clear_i(catch_clear_i),
		.catch_index_i(catch_index_i),
		.catch_count_o(catch_count_o),
		.idle_o(idle_o)
	);

	initial begin
		csa_out_wclk = 1'b0;
		forever #10 csa_out_wclk = ~csa_out_wclk;
	end

	task automatic halt_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_word(input string name, input csa_pkg::csa_word_t exp,
			input csa_pkg::csa_word_t act);
		if (act !== exp) begin
			$display("ERROR %0s expected %h actual %h", name, exp, act);
			halt_run();
		end
	endtask

	task automatic check_count(input string name, input logic [csa_pkg::CATCH_CNT_W-1:0] exp,
			input logic [csa_pkg::CATCH_CNT_W-1:0] act);
		if (act !== exp) begin
			$display("ERROR %0s expected %0d actual %0d", name, exp, act);
			halt_run();
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %0s expected %b actual %b", name, exp, act);
			halt_run();
		end
	endtask

	// Input FIFO model. A word shows up two cycles after its read pulse.
	always @(posedge csa_out_wclk) begin
		if (in_ren_o && rd_ptr < job_words.size()) begin
			rd_stage <= job_words[rd_ptr];
			rd_ptr <= rd_ptr + 1;
		end else begin
			rd_stage <= '0;
		end
		in_rdata_i <= rd_stage;
		in_ready_i <= (job_words.size() - rd_ptr - int'(in_ren_o)) >= csa_pkg::JOB_WORDS;
	end

	// Output FIFO model with random back-pressure.
	always @(posedge csa_out_wclk) begin
		out_full_i <= ($random(seed) & 1) == 1;
		if (rst_n && out_wen_o) begin
			if (burst_len == 0 && full_seen) begin
				$display("An output burst started while the output FIFO was full.");
				halt_run();
			end
			got_words.push_back(out_wdata_o);
			burst_len = burst_len + 1;
		end else if (burst_len != 0) begin
			if (burst_len != csa_pkg::RESULT_WORDS) begin
				$display("An output burst carried %0d words instead of %0d.", burst_len,
					csa_pkg::RESULT_WORDS);
				halt_run();
			end else begin
				burst_len = 0;
			end
		end
		full_seen = out_full_i; // Full as the streamer sampled it at this edge.
	end

	always @(posedge csa_out_wclk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles with %0d output words seen.", cycles,
				got_words.size());
			halt_run();
		end
	end

	initial begin
		integer fd;
		int n;
		int n_jobs;
		logic [8*200-1:0] line_buf;
		logic [127:0] nm;
		csa_pkg::csa_word_t f [7];
		csa_pkg::csa_word_t exp_w;

		rst_n = 1'b0;
		in_ready_i = 1'b0;
		in_rdata_i = '0;
		out_full_i = 1'b0;
		catch_clear_i = 1'b0;
		catch_index_i = '0;
		rd_stage = '0;
		fd = $fopen("csa_cases.txt", "r");
		if (fd == 0) begin
			$display("The case file csa_cases.txt could not be opened.");
			halt_run();
		end
		while ($fgets(line_buf, fd) != 0) begin
			n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h", nm, f[0], f[1], f[2], f[3], f[4],
				f[5], f[6]);
			if (n == 8) begin
				case_names.push_back(nm);
				for (int w = 0; w < csa_pkg::JOB_WORDS; w++) begin
					job_words.push_back(f[w]);
				end
				exp_lo.push_back(f[5]);
				exp_hi.push_back(f[6]);
			end
		end
		$fclose(fd);
		n_jobs = exp_lo.size();
		cycle_limit = n_jobs * 60 + 400;
		for (int i = 0; i < csa_pkg::CATCH_BINS; i++) begin
			exp_cnt[i] = '0;
		end
		for (int j = 0; j < n_jobs; j++) begin
			exp_cnt[exp_lo[j][csa_pkg::CATCH_IDX_W-1:0]] += 1'b1; // Binned by low byte of out.
		end

		repeat (8) @(posedge csa_out_wclk);
		rst_n <= 1'b1;
		while (got_words.size() < n_jobs * csa_pkg::RESULT_WORDS) begin
			@(posedge csa_out_wclk);
			check_level("idle_busy", 1'b0, idle_o);
		end

		for (int j = 0; j < n_jobs; j++) begin
			for (int w = 0; w < csa_pkg::RESULT_WORDS; w++) begin
				if (w < csa_pkg::JOB_WORDS) begin
					exp_w = job_words[j * csa_pkg::JOB_WORDS + w];
				end else if (w == csa_pkg::JOB_WORDS) begin
					exp_w = exp_lo[j];
				end else begin
					exp_w = exp_hi[j];
				end
				check_word($sformatf("%0s word %0d", case_names[j], w), exp_w,
					got_words[j * csa_pkg::RESULT_WORDS + w]);
			end
		end

		repeat (csa_pkg::IDLE_DEBOUNCE + 10) @(posedge csa_out_wclk);
		check_level("idle_drained", 1'b1, idle_o);
		if (got_words.size() != n_jobs * csa_pkg::RESULT_WORDS) begin
			$display("The DUT wrote %0d output words, more than the jobs account for.",
				got_words.size());
			halt_run();
		end

		for (int i = 0; i < csa_pkg::CATCH_BINS; i++) begin
			catch_index_i <= i[csa_pkg::CATCH_IDX_W-1:0];
			@(posedge csa_out_wclk);
			check_count($sformatf("catch bin %0d", i), exp_cnt[i], catch_count_o);
		end
		catch_clear_i <= 1'b1;
		@(posedge csa_out_wclk);
		catch_clear_i <= 1'b0;
		@(posedge csa_out_wclk);
		for (int i = 0; i < csa_pkg::CATCH_BINS; i++) begin
			catch_index_i <= i[csa_pkg::CATCH_IDX_W-1:0];
			@(posedge csa_out_wclk);
			check_count($sformatf("cleared catch bin %0d", i), '0, catch_count_o);
		end

		if (dut0.u_chk.fail_cnt == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("The bound checker saw %0d assertion failures.", dut0.u_chk.fail_cnt);
			halt_run();
		end
	end

endmodule

// File: csa_cases.txt
# name block key_lo key_hi times times_start out_lo out_hi
# all values hex, out is the expected kernel result
zero_iter 11111111 89abcdef 01234567 00000000 deadbeef 89abcdef 01234567
one_iter 00000001 00000001 00000000 00000001 00000000 00000003 00000000
two_iter 000000ff 00000000 00000000 00000002 80000000 00000100 80000000
high_times 12345678 cafef00d 0badf00d fffffff0 55555555 cafef00d 0badf00d
four_iter 00000001 00000000 00000000 00000004 00000000 0000000f 00000000
fifteen_iter 00000001 00000000 00000000 0000001f 00000000 00007fff 00000000
key_rot 00000000 00000000 80000000 00000003 00000000 00000004 00000000
same_byte 00000001 00000001 00000000 00000001 00000010 00000003 00000010
word_carry 00000000 80000000 00000000 00000001 00000000 00000000 00000001

// File: build.f
csa_pkg.sv
csa_job_loader.sv
csa_calc_unit.sv
csa_result_streamer.sv
csa_catch_histogram.sv
csa_idle_monitor.sv
csa_farm_top.sv
csa_farm_chk.sv
tb_csa_farm.sv

// File: Bender.yml
package:
  name: csa_farm

sources:
  - csa_pkg.sv
  - csa_job_loader.sv
  - csa_calc_unit.sv
  - csa_result_streamer.sv
  - csa_catch_histogram.sv
  - csa_idle_monitor.sv
  - csa_farm_top.sv
  - target: test
    files:
      - csa_farm_chk.sv
      - tb_csa_farm.sv
